// File: logic/dct_pkg.sv
// shared DCT constants; IDX_W assumes an 8x8 block indexed as {row, col} with 3-bit halves
package dct_pkg;

  localparam int BLOCK_N    = 8;  // elements per row and per column
  localparam int IDX_W      = 6;  // element index into a 64-entry RAM
  localparam int PIXEL_W    = 8;
  localparam int COEF_W_DEF = 18;

  // coefficient at the default width, as stored in the coefficient RAM
  typedef logic signed [COEF_W_DEF-1:0] coef_t;

  typedef enum logic [4:0] {
    IDLE,
    FETCH_START,
    FETCH_RUN,
    FETCH_END,
    CALC_1,
    CALC_2,
    CALC_3,
    CALC_4,
    CALC_5,
    CALC_6,
    CALC_7,
    SAVE_START,
    SAVE_RUN,
    SAVE_END,
    SCAN_CHECK,
    DONE
  } ctrl_state_t;

endpackage

// File: logic/dct_half_if.sv
// operands are held by the loader until the next load; results follow five cycles after load
`timescale 1ns/1ps

interface dct_half_if
  import dct_pkg::*;
#(
  parameter int COEF_W = COEF_W_DEF
);

  logic signed [COEF_W-1:0] op [4];   // sums or differences of one row
  logic                     load;     // one-cycle strobe, op valid
  logic signed [COEF_W-1:0] res [4];  // even or odd outputs in ascending order

  modport source (
    output op,
    output load
  );

  modport part (
    input  op,
    input  load,
    output res
  );

  modport sink (
    input res
  );

endinterface

// File: logic/dct_block_ctrl.sv
// s_conv is only taken in IDLE; both RAMs must answer reads one cycle after the address
`timescale 1ns/1ps

module dct_block_ctrl
  import dct_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  logic             s_conv,
  output logic [IDX_W-1:0] du_ram_a,
  output logic [IDX_W-1:0] dctdu_ram_ar,
  output logic [IDX_W-1:0] dctdu_ram_aw,
  output logic [2:0]       fetch_idx,
  output logic             fetch_en,
  output logic             vertical,
  output logic             calc_start,
  output logic [2:0]       save_idx,
  output logic             save_en,
  output logic             e_conv
);

  ctrl_state_t      state;
  ctrl_state_t      state_nxt;
  logic [IDX_W-1:0] fetch_cnt;
  logic [IDX_W-1:0] save_cnt;
  logic [IDX_W-1:0] save_cnt_d;  // lines up with the writer's registered data
  logic             vertical_d;
  logic             last_fetch;
  logic             last_save;
  logic             scan_wrap;

  assign last_fetch = &fetch_cnt[2:0];
  assign last_save  = &save_cnt[2:0];
  assign scan_wrap  = (fetch_cnt == '0);  // all eight lines of a pass fetched

  assign du_ram_a     = fetch_cnt;
  assign dctdu_ram_ar = {fetch_cnt[2:0], fetch_cnt[5:3]};  // transposed read
  assign dctdu_ram_aw = vertical ? {save_cnt_d[2:0], save_cnt_d[5:3]} : save_cnt_d;

  assign fetch_en   = (state == FETCH_RUN) || (state == FETCH_END);
  assign calc_start = (state == CALC_1);
  assign save_idx   = save_cnt[2:0];
  assign save_en    = (state == SAVE_START) || (state == SAVE_RUN);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:        if (s_conv) state_nxt = FETCH_START;
      FETCH_START: state_nxt = FETCH_RUN;
      FETCH_RUN:   if (last_fetch) state_nxt = FETCH_END;
      FETCH_END:   state_nxt = CALC_1;
      CALC_1:      state_nxt = CALC_2;
      CALC_2:      state_nxt = CALC_3;
      CALC_3:      state_nxt = CALC_4;
      CALC_4:      state_nxt = CALC_5;
      CALC_5:      state_nxt = CALC_6;
      CALC_6:      state_nxt = CALC_7;
      CALC_7:      state_nxt = SAVE_START;
      SAVE_START:  state_nxt = SAVE_RUN;
      SAVE_RUN:    if (last_save) state_nxt = SAVE_END;
      SAVE_END:    state_nxt = SCAN_CHECK;
      SCAN_CHECK:  state_nxt = (scan_wrap && vertical_d) ? DONE : FETCH_START;
      DONE:        state_nxt = IDLE;
      default:     state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fetch_cnt  <= '0;
      fetch_idx  <= '0;
      save_cnt   <= '0;
      save_cnt_d <= '0;
      vertical   <= 1'b0;
      vertical_d <= 1'b0;
      e_conv     <= 1'b0;
    end else begin
      if ((state == FETCH_START) || (state == FETCH_RUN)) begin
        fetch_cnt <= fetch_cnt + 1'b1;
        fetch_idx <= fetch_cnt[2:0];  // RAM data arrives a cycle later
      end
      if (save_en) begin
        save_cnt <= save_cnt + 1'b1;
      end
      save_cnt_d <= save_cnt;
      if (state == IDLE) begin
        vertical <= 1'b0;
      end else if ((state == SCAN_CHECK) && scan_wrap) begin
        vertical <= 1'b1;  // row pass done, switch to columns
      end
      vertical_d <= vertical;
      e_conv     <= (state == DONE);
    end
  end

endmodule

// File: logic/dct_row_loader.sv
// du_ram_d is sign-extended, so pixel data is expected level-shifted to the signed range
`timescale 1ns/1ps

module dct_row_loader
  import dct_pkg::*;
#(
  parameter int COEF_W = COEF_W_DEF
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic [2:0]               fetch_idx,
  input  logic                     fetch_en,
  input  logic                     vertical,
  input  logic                     calc_start,
  input  logic [PIXEL_W-1:0]       du_ram_d,
  input  logic signed [COEF_W-1:0] dctdu_ram_di,
  dct_half_if.source               even_if,
  dct_half_if.source               odd_if
);

  logic signed [COEF_W-1:0] row_buf [BLOCK_N];
  logic signed [COEF_W-1:0] pixel_ext;

  assign pixel_ext = {{(COEF_W-PIXEL_W){du_ram_d[PIXEL_W-1]}}, du_ram_d};

  always_ff @(posedge clk) begin
    if (fetch_en) begin
      row_buf[fetch_idx] <= vertical ? dctdu_ram_di : pixel_ext;  // column pass reads back
    end
  end

  // first butterfly stage, held until the next row
  always_ff @(posedge clk) begin
    if (calc_start) begin
      even_if.op[0] <= row_buf[0] + row_buf[7];
      even_if.op[1] <= row_buf[1] + row_buf[6];
      even_if.op[2] <= row_buf[2] + row_buf[5];
      even_if.op[3] <= row_buf[3] + row_buf[4];
      odd_if.op[0]  <= row_buf[3] - row_buf[4];
      odd_if.op[1]  <= row_buf[2] - row_buf[5];
      odd_if.op[2]  <= row_buf[1] - row_buf[6];
      odd_if.op[3]  <= row_buf[0] - row_buf[7];
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      even_if.load <= 1'b0;
      odd_if.load  <= 1'b0;
    end else begin
      even_if.load <= calc_start;
      odd_if.load  <= calc_start;
    end
  end

endmodule

// File: logic/dct_even_part.sv
// integer approximation of outputs 0,2,4,6; all arithmetic wraps at COEF_W bits
`timescale 1ns/1ps

module dct_even_part
  import dct_pkg::*;
#(
  parameter int COEF_W = COEF_W_DEF
) (
  input  logic     clk,
  input  logic     reset_n,
  dct_half_if.part even_if
);

  logic [3:0]               stage_en;  // load delayed through the pipe
  logic signed [COEF_W-1:0] a, b, c, e;
  logic signed [COEF_W-1:0] sum_ab, dif_ab, ce, e8;
  logic signed [COEF_W-1:0] z1;
  logic signed [COEF_W-1:0] pos, neg;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stage_en <= '0;
    end else begin
      stage_en <= {stage_en[2:0], even_if.load};
    end
  end

  always_ff @(posedge clk) begin
    if (even_if.load) begin
      a <= even_if.op[0] + even_if.op[3];
      b <= even_if.op[1] + even_if.op[2];
      c <= even_if.op[1] - even_if.op[2];
      e <= even_if.op[0] - even_if.op[3];
    end
    if (stage_en[0]) begin
      sum_ab <= a + b;
      dif_ab <= a - b;
      ce     <= c + e;
      e8     <= e <<< 3;
    end
    if (stage_en[1]) begin
      z1 <= (ce <<< 2) + ce;  // 5*(c+e)
    end
    if (stage_en[2]) begin
      pos <= e8 + z1;
      neg <= e8 - z1;
    end
    if (stage_en[3]) begin
      even_if.res[0] <= sum_ab;
      even_if.res[1] <= pos >>> 3;
      even_if.res[2] <= dif_ab;
      even_if.res[3] <= neg >>> 3;
    end
  end

endmodule

// File: logic/dct_odd_part.sv
// integer approximation of outputs 1,3,5,7; all arithmetic wraps at COEF_W bits
`timescale 1ns/1ps

module dct_odd_part
  import dct_pkg::*;
#(
  parameter int COEF_W = COEF_W_DEF
) (
  input  logic     clk,
  input  logic     reset_n,
  dct_half_if.part odd_if
);

  logic [3:0]               stage_en;
  logic signed [COEF_W-1:0] p, q, r;
  logic signed [COEF_W-1:0] pr, p4, q5, r10, d7_8;
  logic signed [COEF_W-1:0] z5, z11, z13;
  logic signed [COEF_W-1:0] z2, z4;
  logic signed [COEF_W-1:0] sum_11p4, sum_13m2, sum_13p2, sum_11m4;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stage_en <= '0;
    end else begin
      stage_en <= {stage_en[2:0], odd_if.load};
    end
  end

  // sums wrap here, before the final shift
  assign sum_11p4 = z11 + z4;
  assign sum_13m2 = z13 - z2;
  assign sum_13p2 = z13 + z2;
  assign sum_11m4 = z11 - z4;

  always_ff @(posedge clk) begin
    if (odd_if.load) begin
      p <= odd_if.op[0] + odd_if.op[1];
      q <= odd_if.op[1] + odd_if.op[2];
      r <= odd_if.op[2] + odd_if.op[3];
    end
    if (stage_en[0]) begin
      pr   <= p - r;
      p4   <= p <<< 2;
      q5   <= (q <<< 2) + q;
      r10  <= (r <<< 3) + (r <<< 1);
      d7_8 <= odd_if.op[3] <<< 3;  // op still held by the loader
    end
    if (stage_en[1]) begin
      z5  <= (pr <<< 1) + pr;
      z11 <= d7_8 + q5;
      z13 <= d7_8 - q5;
    end
    if (stage_en[2]) begin
      z2 <= p4 + z5;
      z4 <= r10 + z5;
    end
    if (stage_en[3]) begin
      odd_if.res[0] <= sum_11p4 >>> 3;  // out1
      odd_if.res[1] <= sum_13m2 >>> 3;  // out3
      odd_if.res[2] <= sum_13p2 >>> 3;  // out5
      odd_if.res[3] <= sum_11m4 >>> 3;  // out7
    end
  end

endmodule

// File: logic/dct_row_writer.sv
// write data is only meaningful while dctdu_ram_we is high
`timescale 1ns/1ps

module dct_row_writer
  import dct_pkg::*;
#(
  parameter int COEF_W = COEF_W_DEF
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic [2:0]        save_idx,
  input  logic              save_en,
  dct_half_if.sink          even_if,
  dct_half_if.sink          odd_if,
  output logic              dctdu_ram_we,
  output logic [COEF_W-1:0] dctdu_ram_do
);

  logic signed [COEF_W-1:0] row [BLOCK_N];

  always_comb begin
    for (int k = 0; k < BLOCK_N / 2; k++) begin
      row[2*k]   = even_if.res[k];
      row[2*k+1] = odd_if.res[k];
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      dctdu_ram_we <= 1'b0;
    end else begin
      dctdu_ram_we <= save_en;
    end
  end

  always_ff @(posedge clk) begin
    if (save_en) begin
      dctdu_ram_do <= row[save_idx];
    end
  end

endmodule

// File: logic/jpeg_dct_top.sv
// one 8x8 block per s_conv, 418 cycles to e_conv; RAMs need one-cycle reads and never stall
`timescale 1ns/1ps

module jpeg_dct_top
  import dct_pkg::*;
#(
  parameter int COEF_W = COEF_W_DEF
) (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               s_conv,
  output logic [IDX_W-1:0]   du_ram_a,
  input  logic [PIXEL_W-1:0] du_ram_d,
  output logic [IDX_W-1:0]   dctdu_ram_aw,
  output logic               dctdu_ram_we,
  output logic [COEF_W-1:0]  dctdu_ram_do,
  output logic [IDX_W-1:0]   dctdu_ram_ar,
  input  logic [COEF_W-1:0]  dctdu_ram_di,
  output logic               e_conv
);

  logic [2:0] fetch_idx;
  logic       fetch_en;
  logic       vertical;
  logic       calc_start;
  logic [2:0] save_idx;
  logic       save_en;

  dct_half_if #(.COEF_W(COEF_W)) even_if ();
  dct_half_if #(.COEF_W(COEF_W)) odd_if ();

  dct_block_ctrl u_ctrl (
    .clk          (clk),
    .reset_n      (reset_n),
    .s_conv       (s_conv),
    .du_ram_a     (du_ram_a),
    .dctdu_ram_ar (dctdu_ram_ar),
    .dctdu_ram_aw (dctdu_ram_aw),
    .fetch_idx    (fetch_idx),
    .fetch_en     (fetch_en),
    .vertical     (vertical),
    .calc_start   (calc_start),
    .save_idx     (save_idx),
    .save_en      (save_en),
    .e_conv       (e_conv)
  );

  dct_row_loader #(.COEF_W(COEF_W)) u_loader (
    .clk          (clk),
    .reset_n      (reset_n),
    .fetch_idx    (fetch_idx),
    .fetch_en     (fetch_en),
    .vertical     (vertical),
    .calc_start   (calc_start),
    .du_ram_d     (du_ram_d),
    .dctdu_ram_di (dctdu_ram_di),
    .even_if      (even_if.source),
    .odd_if       (odd_if.source)
  );

  dct_even_part #(.COEF_W(COEF_W)) u_even (
    .clk     (clk),
    .reset_n (reset_n),
    .even_if (even_if.part)
  );

  dct_odd_part #(.COEF_W(COEF_W)) u_odd (
    .clk     (clk),
    .reset_n (reset_n),
    .odd_if  (odd_if.part)
  );

  dct_row_writer #(.COEF_W(COEF_W)) u_writer (
    .clk          (clk),
    .reset_n      (reset_n),
    .save_idx     (save_idx),
    .save_en      (save_en),
    .even_if      (even_if.sink),
    .odd_if       (odd_if.sink),
    .dctdu_ram_we (dctdu_ram_we),
    .dctdu_ram_do (dctdu_ram_do)
  );

endmodule

// File: test/jpeg_dct_properties.sv
// checks port-level protocol only; bound into every jpeg_dct_top instance
`timescale 1ns/1ps

module jpeg_dct_properties (
  input logic clk,
  input logic reset_n,
  input logic e_conv,
  input logic dctdu_ram_we
);

  int fail_count = 0;

  // done is a single-cycle pulse
  assert property (@(posedge clk) disable iff (!reset_n) e_conv |=> !e_conv)
    else begin
      fail_count++;
      $error("e_conv high for more than one cycle");
    end

  // one row or column is saved as a burst of eight writes
  assert property (@(posedge clk) disable iff (!reset_n)
    $rose(dctdu_ram_we) |-> dctdu_ram_we [*8] ##1 !dctdu_ram_we)
    else begin
      fail_count++;
      $error("dctdu_ram_we burst is not eight cycles long");
    end

  assert property (@(posedge clk) disable iff (!reset_n) !(e_conv && dctdu_ram_we))
    else begin
      fail_count++;
      $error("e_conv and dctdu_ram_we high together");
    end

endmodule

bind jpeg_dct_top jpeg_dct_properties props0 (
  .clk          (clk),
  .reset_n      (reset_n),
  .e_conv       (e_conv),
  .dctdu_ram_we (dctdu_ram_we)
);

// File: test/tb_jpeg_dct.sv
// expects test/dct_golden.txt relative to the run directory; both RAMs are modeled here
`timescale 1ns/1ps

module tb_jpeg_dct;

  localparam int NUM_BLOCKS = 6;
  localparam int TIMEOUT    = 1000;  // cycles, block needs 418

  logic        clk;
  logic        reset_n;
  logic        s_conv;
  logic [5:0]  du_ram_a;
  logic [7:0]  du_ram_d;
  logic [5:0]  dctdu_ram_aw;
  logic        dctdu_ram_we;
  logic [17:0] dctdu_ram_do;
  logic [5:0]  dctdu_ram_ar;
  logic [17:0] dctdu_ram_di;
  logic        e_conv;

  logic [7:0]  pix_mem [64];
  logic [17:0] coef_mem [64];
  logic [7:0]  gold_pix [NUM_BLOCKS][64];
  logic [17:0] gold_coef [NUM_BLOCKS][64];
  int          row_hits [64];
  int          col_hits [64];
  int          wr_total;
  int          e_count;
  int          errors;
  bit          stop_run;  // no golden data or a block hung
  logic [5:0]  rd_a, rd_ar, wr_aw;
  logic        wr_we;
  logic [17:0] wr_do;

  jpeg_dct_top #(.COEF_W(18)) dut0 (.*);

  always #50 clk = ~clk;

  // addresses sampled mid-cycle, data returned just after the next edge
  always @(negedge clk) begin
    rd_a  = du_ram_a;
    rd_ar = dctdu_ram_ar;
    wr_aw = dctdu_ram_aw;
    wr_we = dctdu_ram_we;
    wr_do = dctdu_ram_do;
    if (e_conv) e_count++;
  end

  always @(posedge clk) begin
    #1;
    du_ram_d     = pix_mem[rd_a];
    dctdu_ram_di = coef_mem[rd_ar];  // read before write
    if (wr_we) begin
      coef_mem[wr_aw] = wr_do;
      if (wr_total < 64) row_hits[wr_aw]++;
      else col_hits[wr_aw]++;
      wr_total++;
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic read_golden();
    int    fd;
    int    val;
    string line;
    fd = $fopen("test/dct_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open golden file test/dct_golden.txt");
      errors++;
      stop_run = 1'b1;
    end else begin
      void'($fgets(line, fd));  // two header lines
      void'($fgets(line, fd));
      for (int b = 0; b < NUM_BLOCKS; b++) begin
        for (int i = 0; i < 64; i++) begin
          if ($fscanf(fd, "%h", val) != 1) begin
            $display("golden file too short, pixel %0d of block %0d missing", i, b);
            errors++;
          end
          gold_pix[b][i] = val[7:0];
        end
        for (int i = 0; i < 64; i++) begin
          if ($fscanf(fd, "%h", val) != 1) begin
            $display("golden file too short, coefficient %0d of block %0d missing", i, b);
            errors++;
          end
          gold_coef[b][i] = val[17:0];
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_block(input int b);
    int start_e;
    int cycles;
    int extra_at;
    for (int i = 0; i < 64; i++) begin
      pix_mem[i]  = gold_pix[b][i];
      coef_mem[i] = 18'h15a00 ^ {12'h0, i[5:0]};
      row_hits[i] = 0;
      col_hits[i] = 0;
    end
    wr_total = 0;
    repeat ($urandom_range(1, 6)) @(posedge clk);
    start_e  = e_count;
    extra_at = $urandom_range(5, 400);  // stray start while busy
    @(posedge clk);
    #1 s_conv = 1'b1;
    cycles = 0;
    while (e_count == start_e && cycles < TIMEOUT) begin
      @(posedge clk);
      #1 s_conv = (cycles == extra_at);
      cycles++;
    end
    s_conv = 1'b0;
    if (cycles >= TIMEOUT) begin
      $display("timeout, no e_conv within %0d cycles in block %0d", TIMEOUT, b);
      errors++;
      stop_run = 1'b1;
    end else begin
      repeat ($urandom_range(3, 10)) @(posedge clk);
      check_value(e_count - start_e, 1, $sformatf("block %0d e_conv pulses", b));
      check_value(wr_total, 128, $sformatf("block %0d write count", b));
      for (int i = 0; i < 64; i++) begin
        check_value(coef_mem[i], gold_coef[b][i], $sformatf("block %0d coef[%0d]", b, i));
        check_value(row_hits[i], 1, $sformatf("block %0d row writes at %0d", b, i));
        check_value(col_hits[i], 1, $sformatf("block %0d column writes at %0d", b, i));
      end
    end
  endtask

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    s_conv       = 1'b0;
    du_ram_d     = '0;
    dctdu_ram_di = '0;
    errors       = 0;
    e_count      = 0;
    wr_total     = 0;
    stop_run     = 1'b0;
    void'($urandom(42));
    for (int i = 0; i < 64; i++) begin
      pix_mem[i]  = i[7:0];
      coef_mem[i] = 18'h15a00 ^ {12'h0, i[5:0]};
    end
    read_golden();
    for (int c = 0; c < 15; c++) begin
      @(negedge clk);
      check_value(dctdu_ram_we, 0, "dctdu_ram_we before start");
      check_value(e_conv, 0, "e_conv before start");
      if (c == 9) #51 reset_n = 1'b1;  // release just after a rising edge
    end
    check_value(wr_total, 0, "writes before start");
    for (int b = 0; b < NUM_BLOCKS && !stop_run; b++) begin
      run_block(b);
    end
    check_value(dut0.props0.fail_count, 0, "assertion failures");
    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
logic/dct_pkg.sv
logic/dct_half_if.sv
logic/dct_block_ctrl.sv
logic/dct_row_loader.sv
logic/dct_even_part.sv
logic/dct_odd_part.sv
logic/dct_row_writer.sv
logic/jpeg_dct_top.sv
test/jpeg_dct_properties.sv
test/tb_jpeg_dct.sv

// File: Makefile
# Verilator build for the JPEG DCT testbench; run from the project root
VERILATOR ?= verilator
TOP       ?= tb_jpeg_dct
SEED      ?= 42
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
PASS_MSG  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/dct_golden.txt
// per block: one line of 64 pixels (hex, row-major), then one line of 64 coefficients
// coefficients are 18-bit hex, address u*8+v
10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10
400 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
3ffc0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
10 0 0 0 0 0 0 0 10 0 0 0 0 0 0 0 10 0 0 0 0 0 0 0 10 0 0 0 0 0 0 0 10 0 0 0 0 0 0 0 10 0 0 0 0 0 0 0 10 0 0 0 0 0 0 0 10 0 0 0 0 0 0 0
80 f0 d0 b0 80 50 30 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 2 2 2 2 2 2 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
10 0 0 0 0 0 0 0 1e 0 0 0 0 0 0 0 1a 0 0 0 0 0 0 0 16 0 0 0 0 0 0 0 10 0 0 0 0 0 0 0 a 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0
7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
1fc0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
